// File: dcache.f
+incdir+logic
logic/dcache_pkg.sv
logic/dcache_way.sv
logic/dcache_lru.sv
logic/dcache_ctrl.sv
logic/main_mem.sv
logic/dcache_top.sv
dv/dcache_tb.sv

// File: dv/dcache_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_tb
	import dcache_pkg::*;
();

	localparam int CLK_PERIOD        = 20;
	localparam int RESET_CYCLES      = 5;
	localparam int RANDOM_ACCESSES   = 200;
	localparam int NUM_ACCESSES      = 19 + RANDOM_ACCESSES;  // directed tests plus random run
	localparam int CYCLES_PER_ACCESS = 3 * `DC_MEM_LATENCY + 10;
	localparam int WATCHDOG_CYCLES   = NUM_ACCESSES * CYCLES_PER_ACCESS + RESET_CYCLES;

	logic  clk;
	logic  rst;
	logic  i_rd;
	logic  i_wr;
	addr_t i_addr;
	word_t i_wdata;
	logic  o_ready;
	word_t o_rdata;

	word_t       shadow [1 << `DC_ADDR_W];  // expected contents of every word
	logic [31:0] lfsr;
	logic        first_ready;  // o_ready in the cycle the request went out
	int          value_errors;
	int          other_errors;

	dcache_top UUT (
		.clk(clk), .rst(rst),
		.i_rd(i_rd), .i_wr(i_wr), .i_addr(i_addr), .i_wdata(i_wdata),
		.o_ready(o_ready), .o_rdata(o_rdata)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the tests never finished", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			val  = {val[30:0], lfsr[0]};  // one step per bit
		end
	endtask

	task automatic compare_word(input string name, input addr_t addr,
			input word_t expected, input word_t actual);
		if (actual !== expected) begin
			value_errors++;
			$display("Error: %s at address %h expected %h got %h", name, addr, expected, actual);
		end
	endtask

	task automatic compare_ready(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			value_errors++;
			$display("Error: %s expected %h got %h", name, expected, actual);
		end
	endtask

	// one request held until the cache takes it
	task automatic access(input logic wr, input addr_t addr, input word_t wdata,
			output word_t rdata);
		int waited;
		waited = 0;
		rdata  = '0;
		@(posedge clk);
		#2;
		i_rd    = ~wr;
		i_wr    = wr;
		i_addr  = addr;
		i_wdata = wdata;
		@(negedge clk);
		first_ready = o_ready;
		while (!o_ready && waited < CYCLES_PER_ACCESS) begin
			waited++;
			@(negedge clk);
		end
		if (o_ready) begin
			rdata = o_rdata;  // settled mid-cycle
		end else begin
			other_errors++;
			$display("Access to address %h never completed, o_ready stayed low for %0d cycles",
				addr, waited);
		end
		@(posedge clk);
		#2;
		i_rd = 1'b0;
		i_wr = 1'b0;
	endtask

	task automatic write_word(input addr_t addr, input word_t data);
		word_t unused;
		access(1'b1, addr, data, unused);
		shadow[addr] = data;
	endtask

	task automatic read_check(input addr_t addr);
		word_t got;
		access(1'b0, addr, '0, got);
		compare_word("o_rdata", addr, shadow[addr], got);
	endtask

	task automatic test_reset_read();
		word_t got;
		@(negedge clk);
		compare_ready("o_ready after reset", 1'b1, o_ready);
		access(1'b0, 16'h1234, '0, got);
		compare_word("o_rdata", 16'h1234, 16'h1234, got);  // untouched word holds its address
		access(1'b0, 16'hbeef, '0, got);
		compare_word("o_rdata", 16'hbeef, 16'hbeef, got);
	endtask

	task automatic test_write_read();
		addr_t base;
		base = 16'h0488;
		write_word(base | 16'h2, 16'ha5c3);
		for (int w = 0; w < `DC_WORDS_PER_LINE; w++) begin
			read_check(base | addr_t'(w));
		end
	endtask

	// two tags in the same set
	task automatic test_two_ways();
		addr_t a;
		addr_t b;
		a = {9'h011, 5'd7, 2'd1};
		b = {9'h052, 5'd7, 2'd1};
		read_check(a);
		read_check(b);
		// both lines stay resident, so every access below hits
		write_word(a, 16'h1111);
		compare_ready("o_ready on write hit", 1'b1, first_ready);
		write_word(b, 16'h2222);
		compare_ready("o_ready on write hit", 1'b1, first_ready);
		read_check(a);
		compare_ready("o_ready on read hit", 1'b1, first_ready);
		read_check(b);
		compare_ready("o_ready on read hit", 1'b1, first_ready);
	endtask

	task automatic test_dirty_evict();
		addr_t a;
		addr_t b;
		addr_t c;
		a = {9'h0a0, 5'd12, 2'd3};
		b = {9'h0a1, 5'd12, 2'd3};
		c = {9'h0a2, 5'd12, 2'd3};
		write_word(a, 16'hd00d);
		write_word(b, 16'hcafe);
		write_word(c, 16'hf00d);  // a is least recent and goes out dirty
		read_check(a);
		read_check(b);
		read_check(c);
	endtask

	task automatic test_random();
		logic [31:0] r_tag;
		logic [31:0] r_index;
		logic [31:0] r_offset;
		logic [31:0] r_wr;
		logic [31:0] r_data;
		addr_t       addr;
		for (int n = 0; n < RANDOM_ACCESSES; n++) begin
			random_bits(3, r_tag);
			random_bits(5, r_index);
			random_bits(2, r_offset);
			random_bits(1, r_wr);
			random_bits(16, r_data);
			addr = {6'h15, r_tag[2:0], r_index[4:0], r_offset[1:0]};  // 8 tags in play
			if (r_wr[0]) begin
				write_word(addr, r_data[15:0]);
			end else begin
				read_check(addr);
			end
		end
	endtask

	initial begin
		rst          = 1'b1;
		i_rd         = 1'b0;
		i_wr         = 1'b0;
		i_addr       = '0;
		i_wdata      = '0;
		value_errors = 0;
		other_errors = 0;
		lfsr         = 32'h8ad175ff;
		for (int a = 0; a < (1 << `DC_ADDR_W); a++) begin
			shadow[a] = word_t'(a);
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst = 1'b0;

		test_reset_read();
		test_write_read();
		test_two_ways();
		test_dirty_evict();
		test_random();

		$display("Errors: %0d wrong values, %0d incomplete accesses", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/dcache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_ctrl
	import dcache_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	// requester
	input  logic       i_rd,
	input  logic       i_wr,
	input  addr_t      i_addr,
	input  word_t      i_wdata,
	output logic       o_ready,
	output word_t      o_rdata,
	// way 0 and way 1 lookup
	input  logic       i_hit0,
	input  logic       i_valid0,
	input  logic       i_dirty0,
	input  tag_t       i_tag0,
	input  line_t      i_line0,
	input  logic       i_hit1,
	input  logic       i_valid1,
	input  logic       i_dirty1,
	input  tag_t       i_tag1,
	input  line_t      i_line1,
	output index_t     o_index,
	output tag_t       o_tag,
	output logic       o_we0,
	output logic       o_we1,
	output logic       o_set_valid,
	output logic       o_set_dirty,
	output line_t      o_wline,
	// replacement
	input  way_t       i_victim_way,
	output logic       o_touch,
	output way_t       o_used_way,
	// backing memory
	input  logic       i_mem_ack,
	input  line_t      i_mem_rdata,
	output logic       o_mem_rd,
	output logic       o_mem_wr,
	output line_addr_t o_mem_addr,
	output line_t      o_mem_wdata
);

	ctrl_state_t state_q;
	ctrl_state_t state_d;
	way_t        victim_q;
	line_t       refill_q;

	tag_t    req_tag;
	index_t  req_index;
	offset_t req_offset;
	logic    req;
	logic    hit;
	logic    idle;
	logic    miss;
	logic    wr_hit;
	logic    refill;
	way_t    hit_way;
	line_t   hit_line;
	line_t   merged_line;
	way_t    cur_victim;
	logic    victim_valid;
	logic    victim_dirty;
	tag_t    victim_tag;

	assign {req_tag, req_index, req_offset} = i_addr;

	assign req     = i_rd | i_wr;
	assign hit     = i_hit0 | i_hit1;
	assign idle    = (state_q == ST_IDLE);
	assign miss    = idle & req & ~hit;
	assign wr_hit  = idle & i_wr & hit;
	assign refill  = (state_q == ST_REFILL);
	assign hit_way = i_hit1;  // a tag lives in one way at most

	assign hit_line = i_hit1 ? i_line1 : i_line0;
	assign o_rdata  = hit_line[req_offset*`DC_WORD_W +: `DC_WORD_W];

	// write hit replaces one word of the hitting line
	always_comb begin
		merged_line = hit_line;
		merged_line[req_offset*`DC_WORD_W +: `DC_WORD_W] = i_wdata;
	end

	// victim comes from the LRU on the miss cycle, then from the latch
	assign cur_victim   = idle ? i_victim_way : victim_q;
	assign victim_valid = cur_victim ? i_valid1 : i_valid0;
	assign victim_dirty = victim_valid & (cur_victim ? i_dirty1 : i_dirty0);
	assign victim_tag   = cur_victim ? i_tag1 : i_tag0;

	// requester stalls on anything but an idle hit
	assign o_ready = idle & ~(req & ~hit);

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (miss) begin
					state_d = victim_dirty ? ST_WRITEBACK : ST_FETCH;
				end
			end
			ST_WRITEBACK: begin
				if (i_mem_ack) begin
					state_d = ST_FETCH;
				end
			end
			ST_FETCH: begin
				if (i_mem_ack) begin
					state_d = ST_REFILL;
				end
			end
			ST_REFILL: state_d = ST_IDLE;  // held request hits next cycle
			default:   state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q  <= ST_IDLE;
			victim_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (miss) begin
				victim_q <= i_victim_way;
			end
		end
	end

	always_ff @(posedge clk) begin
		if ((state_q == ST_FETCH) && i_mem_ack) begin
			refill_q <= i_mem_rdata;
		end
	end

	// memory request starts in the miss cycle itself
	assign o_mem_wr    = (state_q == ST_WRITEBACK) | (miss & victim_dirty);
	assign o_mem_rd    = (state_q == ST_FETCH) | (miss & ~victim_dirty);
	assign o_mem_addr  = o_mem_wr ? {victim_tag, req_index} : {req_tag, req_index};
	assign o_mem_wdata = cur_victim ? i_line1 : i_line0;

	assign o_index     = req_index;
	assign o_tag       = req_tag;
	assign o_we0       = (wr_hit & ~hit_way) | (refill & ~victim_q);
	assign o_we1       = (wr_hit & hit_way) | (refill & victim_q);
	assign o_set_valid = wr_hit | refill;
	assign o_set_dirty = wr_hit;  // refilled lines start clean
	assign o_wline     = refill ? refill_q : merged_line;

	assign o_touch    = idle & req & hit;
	assign o_used_way = hit_way;

endmodule

`default_nettype wire

// File: logic/dcache_lru.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_lru
	import dcache_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  index_t i_index,
	input  logic   i_touch,
	input  way_t   i_used_way,
	input  logic   i_valid0,
	input  logic   i_valid1,
	output way_t   o_victim_way
);

	localparam int SETS = 1 << `DC_INDEX_W;

	logic [SETS-1:0] mru_q;  // way used most recently, per set

	always_ff @(posedge clk) begin
		if (rst) begin
			mru_q <= '0;
		end else if (i_touch) begin
			mru_q[i_index] <= i_used_way;
		end
	end

	// empty ways fill first, way 0 before way 1
	always_comb begin
		if (!i_valid0) begin
			o_victim_way = 1'b0;
		end else if (!i_valid1) begin
			o_victim_way = 1'b1;
		end else begin
			o_victim_way = ~mru_q[i_index];
		end
	end

endmodule

`default_nettype wire

// File: logic/dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// word-addressed data cache geometry
`define DC_ADDR_W          16
`define DC_WORD_W          16
`define DC_OFFSET_W        2   // word within a line
`define DC_INDEX_W         5   // 32 sets
`define DC_TAG_W           9
`define DC_WORDS_PER_LINE  4
`define DC_LINE_W          64
`define DC_LINE_ADDR_W     14  // tag plus index

// backing memory latency from request to ack
`define DC_MEM_LATENCY     3

`endif

// File: logic/dcache_pkg.sv
`default_nettype none

`include "dcache_macros.svh"

package dcache_pkg;

	// address fields from high to low are tag, index and offset
	typedef logic [`DC_ADDR_W-1:0]      addr_t;
	typedef logic [`DC_WORD_W-1:0]      word_t;
	typedef logic [`DC_LINE_W-1:0]      line_t;   // word 0 in the low bits
	typedef logic [`DC_TAG_W-1:0]       tag_t;
	typedef logic [`DC_INDEX_W-1:0]     index_t;
	typedef logic [`DC_OFFSET_W-1:0]    offset_t;
	typedef logic [`DC_LINE_ADDR_W-1:0] line_addr_t;
	typedef logic                       way_t;

	// miss handling
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WRITEBACK,  // dirty victim going out
		ST_FETCH,      // missing line coming in
		ST_REFILL
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: logic/dcache_top.sv
`timescale 1ns/100ps
`default_nettype none

module dcache_top
	import dcache_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  i_rd,
	input  logic  i_wr,
	input  addr_t i_addr,
	input  word_t i_wdata,
	output logic  o_ready,
	output word_t o_rdata
);

	index_t     index;
	tag_t       tag;
	logic       we0, we1, set_valid, set_dirty;
	line_t      wline;
	logic       hit0, valid0, dirty0;
	logic       hit1, valid1, dirty1;
	tag_t       tag0, tag1;
	line_t      line0, line1;
	logic       touch;
	way_t       used_way, victim_way;
	logic       mem_rd, mem_wr, mem_ack;
	line_addr_t mem_addr;
	line_t      mem_wdata, mem_rdata;

	dcache_ctrl u_ctrl (
		.clk(clk), .rst(rst),
		.i_rd(i_rd), .i_wr(i_wr), .i_addr(i_addr), .i_wdata(i_wdata),
		.o_ready(o_ready), .o_rdata(o_rdata),
		.i_hit0(hit0), .i_valid0(valid0), .i_dirty0(dirty0), .i_tag0(tag0), .i_line0(line0),
		.i_hit1(hit1), .i_valid1(valid1), .i_dirty1(dirty1), .i_tag1(tag1), .i_line1(line1),
		.o_index(index), .o_tag(tag), .o_we0(we0), .o_we1(we1),
		.o_set_valid(set_valid), .o_set_dirty(set_dirty), .o_wline(wline),
		.i_victim_way(victim_way), .o_touch(touch), .o_used_way(used_way),
		.i_mem_ack(mem_ack), .i_mem_rdata(mem_rdata),
		.o_mem_rd(mem_rd), .o_mem_wr(mem_wr), .o_mem_addr(mem_addr), .o_mem_wdata(mem_wdata)
	);

	dcache_way way0 (
		.clk(clk), .rst(rst), .i_index(index), .i_tag(tag), .i_we(we0),
		.i_set_valid(set_valid), .i_set_dirty(set_dirty), .i_wline(wline),
		.o_hit(hit0), .o_valid(valid0), .o_dirty(dirty0), .o_tag(tag0), .o_line(line0)
	);

	dcache_way way1 (
		.clk(clk), .rst(rst), .i_index(index), .i_tag(tag), .i_we(we1),
		.i_set_valid(set_valid), .i_set_dirty(set_dirty), .i_wline(wline),
		.o_hit(hit1), .o_valid(valid1), .o_dirty(dirty1), .o_tag(tag1), .o_line(line1)
	);

	dcache_lru u_lru (
		.clk(clk), .rst(rst), .i_index(index), .i_touch(touch), .i_used_way(used_way),
		.i_valid0(valid0), .i_valid1(valid1), .o_victim_way(victim_way)
	);

	main_mem u_mem (
		.clk(clk), .rst(rst), .i_rd(mem_rd), .i_wr(mem_wr), .i_addr(mem_addr),
		.i_wdata(mem_wdata), .o_ack(mem_ack), .o_rdata(mem_rdata)
	);

endmodule

`default_nettype wire

// File: logic/dcache_way.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_way
	import dcache_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  index_t i_index,
	input  tag_t   i_tag,
	input  logic   i_we,
	input  logic   i_set_valid,
	input  logic   i_set_dirty,
	input  line_t  i_wline,
	output logic   o_hit,
	output logic   o_valid,
	output logic   o_dirty,
	output tag_t   o_tag,
	output line_t  o_line
);

	localparam int SETS = 1 << `DC_INDEX_W;

	logic [SETS-1:0] valid_q;
	logic [SETS-1:0] dirty_q;
	tag_t            tag_mem [SETS];
	line_t           line_mem [SETS];

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
		end else if (i_we) begin
			valid_q[i_index] <= i_set_valid;
		end
	end

	// dirty only counts while the entry is valid
	always_ff @(posedge clk) begin
		if (i_we) begin
			dirty_q[i_index]  <= i_set_dirty;
			tag_mem[i_index]  <= i_tag;
			line_mem[i_index] <= i_wline;
		end
	end

	assign o_valid = valid_q[i_index];
	assign o_dirty = dirty_q[i_index];
	assign o_tag   = tag_mem[i_index];
	assign o_line  = line_mem[i_index];
	assign o_hit   = o_valid && (o_tag == i_tag);  // same-cycle lookup

endmodule

`default_nettype wire

// File: logic/main_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_macros.svh"

module main_mem
	import dcache_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       i_rd,
	input  logic       i_wr,
	input  line_addr_t i_addr,
	input  line_t      i_wdata,
	output logic       o_ack,
	output line_t      o_rdata
);

	localparam int LINES = 1 << `DC_LINE_ADDR_W;
	localparam int CNT_W = $clog2(`DC_MEM_LATENCY + 1);

	line_t            mem [LINES];
	logic [CNT_W-1:0] cnt_q;  // cycles the current request has waited
	logic             req;

	// every word starts out holding its own word address
	initial begin
		for (int l = 0; l < LINES; l++) begin
			for (int w = 0; w < `DC_WORDS_PER_LINE; w++) begin
				mem[l][w*`DC_WORD_W +: `DC_WORD_W] = word_t'(l * `DC_WORDS_PER_LINE + w);
			end
		end
	end

	assign req   = i_rd | i_wr;
	assign o_ack = req && (cnt_q == CNT_W'(`DC_MEM_LATENCY));

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt_q <= '0;
		end else if (!req || o_ack) begin
			cnt_q <= '0;  // next request starts a fresh count
		end else begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (i_wr && o_ack) begin
			mem[i_addr] <= i_wdata;
		end
	end

	assign o_rdata = mem[i_addr];  // sampled by the cache in the ack cycle

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the data cache testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module dcache_tb -f dcache.f -o dcache_sim
./obj_dir/dcache_sim | tee "$LOG"

if grep -q "Simulation completed successfully" "$LOG"; then
	echo "run_sim: testbench passed"
else
	echo "run_sim: testbench reported failure, see $LOG"
	exit 1
fi
